// File: src/kbd_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT keyboard port constants
// Frame format, synchronizer depth and special codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef KBD_SETTINGS_SVH
`define KBD_SETTINGS_SVH

// Scan code and frame shape
`define KBD_SCAN_W        8
`define KBD_FRAME_BITS    11   // Start, 8 data, parity, stop

// Flops per keyboard line in the synchronizer
`define KBD_SYNC_STAGES   2

// Protocol bytes
`define KBD_BREAK_PREFIX  8'hF0  // Set-2 release prefix
`define KBD_BREAK_BIT     7      // Set-1 release flag
`define KBD_SELF_TEST_OK  8'hAA  // Reported after a keyboard reset

`endif

// File: src/kbd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT keyboard port types
// Scan-code type and state encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "kbd_settings.svh"

package kbd_pkg;

	// One scan code, set 2 or set 1
	typedef logic [`KBD_SCAN_W-1:0] scan_code_t;

	// PS/2 receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,   // Waiting for start bit
		RX_DATA,   // Shifting eight data bits
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	// Host side FSM
	typedef enum logic [2:0] {
		HS_IDLE,
		HS_HOLD,        // Code on pa, irq1 high
		HS_ACK,         // Waiting for pb7 to drop
		HS_BREAK_WAIT,  // Prefix seen
		HS_RST_LOW,     // pb6 held low
		HS_RST_WAIT     // pb6 released, waiting for pb7 low
	} host_state_e;

endpackage

// File: src/ps2_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 frame receiver
// Synchronizes keyboard clock and data, deserializes
// one 11-bit frame into a byte with a done strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "kbd_settings.svh"

module ps2_receiver import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output scan_code_t rx_code,
	output logic       rx_done
);

	logic [`KBD_SYNC_STAGES-1:0] clk_sync;
	logic [`KBD_SYNC_STAGES-1:0] data_sync;
	logic                        clk_prev;
	logic                        clk_fall;
	logic                        data_bit;
	logic [3:0]                  edge_cnt;   // Falling edges seen in this frame
	scan_code_t                  shift_reg;
	rx_state_e                   state;

	// Both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[`KBD_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[`KBD_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_sync[`KBD_SYNC_STAGES-1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[`KBD_SYNC_STAGES-1];
	assign data_bit = data_sync[`KBD_SYNC_STAGES-1]; // Same delay as the clock path

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (clk_fall && state == RX_DATA) begin
			shift_reg <= {data_bit, shift_reg[`KBD_SCAN_W-1:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			edge_cnt <= '0;
			rx_code  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (clk_fall) begin
				edge_cnt <= edge_cnt + 4'd1;
				case (state)
					RX_IDLE: begin
						// Only a low start bit opens a frame
						if (!data_bit) begin
							state    <= RX_DATA;
							edge_cnt <= 4'd1;
						end
					end
					RX_DATA: begin
						if (edge_cnt == 4'(`KBD_SCAN_W)) begin
							state <= RX_PARITY;
						end
					end
					RX_PARITY: state <= RX_STOP;  // Parity bit passed over
					RX_STOP: begin
						state    <= RX_IDLE;
						edge_cnt <= '0;
						// Framing check on the last edge
						if (edge_cnt == 4'(`KBD_FRAME_BITS - 1) && data_bit) begin
							rx_code <= shift_reg;
							rx_done <= 1'b1;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Edges are at least two clk cycles apart after the synchronizer
	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done lasted two cycles");

endmodule

// File: src/scan_translator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan code translator
// Maps set-2 keyboard codes to XT set-1 codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scan_translator import kbd_pkg::*; (
	input  scan_code_t rx_code,
	output scan_code_t xt_code
);

	always_comb begin
		case (rx_code)
			8'h00: xt_code = 8'hFF;  // Error / overrun
			8'h01: xt_code = 8'h43;
			8'h02: xt_code = 8'h41;
			8'h03: xt_code = 8'h3F;
			8'h04: xt_code = 8'h3D;
			8'h05: xt_code = 8'h3B;
			8'h06: xt_code = 8'h3C;
			8'h07: xt_code = 8'h58;
			8'h08: xt_code = 8'h64;
			8'h09: xt_code = 8'h44;
			8'h0A: xt_code = 8'h42;
			8'h0B: xt_code = 8'h40;
			8'h0C: xt_code = 8'h3E;
			8'h0D: xt_code = 8'h0F;
			8'h0E: xt_code = 8'h29;
			8'h0F: xt_code = 8'h59;
			8'h10: xt_code = 8'h65;
			8'h11: xt_code = 8'h38;
			8'h12: xt_code = 8'h2A;
			8'h13: xt_code = 8'h70;
			8'h14: xt_code = 8'h1D;
			8'h15: xt_code = 8'h10;
			8'h16: xt_code = 8'h02;
			8'h17: xt_code = 8'h5A;
			8'h18: xt_code = 8'h66;
			8'h19: xt_code = 8'h71;
			8'h1A: xt_code = 8'h2C;
			8'h1B: xt_code = 8'h1F;
			8'h1C: xt_code = 8'h1E;
			8'h1D: xt_code = 8'h11;
			8'h1E: xt_code = 8'h03;
			8'h1F: xt_code = 8'h5B;
			8'h20: xt_code = 8'h67;
			8'h21: xt_code = 8'h2E;
			8'h22: xt_code = 8'h2D;
			8'h23: xt_code = 8'h20;
			8'h24: xt_code = 8'h12;
			8'h25: xt_code = 8'h05;
			8'h26: xt_code = 8'h04;
			8'h27: xt_code = 8'h5C;
			8'h28: xt_code = 8'h68;
			8'h29: xt_code = 8'h39;  // Space
			8'h2A: xt_code = 8'h2F;
			8'h2B: xt_code = 8'h21;
			8'h2C: xt_code = 8'h14;
			8'h2D: xt_code = 8'h13;
			8'h2E: xt_code = 8'h06;
			8'h2F: xt_code = 8'h5D;
			8'h30: xt_code = 8'h69;
			8'h31: xt_code = 8'h31;
			8'h32: xt_code = 8'h30;
			8'h33: xt_code = 8'h23;
			8'h34: xt_code = 8'h22;
			8'h35: xt_code = 8'h15;
			8'h36: xt_code = 8'h07;
			8'h37: xt_code = 8'h5E;
			8'h38: xt_code = 8'h6A;
			8'h39: xt_code = 8'h72;
			8'h3A: xt_code = 8'h32;
			8'h3B: xt_code = 8'h24;
			8'h3C: xt_code = 8'h16;
			8'h3D: xt_code = 8'h08;
			8'h3E: xt_code = 8'h09;
			8'h3F: xt_code = 8'h5F;
			8'h40: xt_code = 8'h6B;
			8'h41: xt_code = 8'h33;
			8'h42: xt_code = 8'h25;
			8'h43: xt_code = 8'h17;
			8'h44: xt_code = 8'h18;
			8'h45: xt_code = 8'h0B;
			8'h46: xt_code = 8'h0A;
			8'h47: xt_code = 8'h60;
			8'h48: xt_code = 8'h6C;
			8'h49: xt_code = 8'h34;
			8'h4A: xt_code = 8'h35;
			8'h4B: xt_code = 8'h26;
			8'h4C: xt_code = 8'h27;
			8'h4D: xt_code = 8'h19;
			8'h4E: xt_code = 8'h0C;
			8'h4F: xt_code = 8'h61;
			8'h50: xt_code = 8'h6D;
			8'h51: xt_code = 8'h73;
			8'h52: xt_code = 8'h28;
			8'h53: xt_code = 8'h74;
			8'h54: xt_code = 8'h1A;
			8'h55: xt_code = 8'h0D;
			8'h56: xt_code = 8'h62;
			8'h57: xt_code = 8'h6E;
			8'h58: xt_code = 8'h3A;
			8'h59: xt_code = 8'h36;
			8'h5A: xt_code = 8'h1C;  // Enter
			8'h5B: xt_code = 8'h1B;
			8'h5C: xt_code = 8'h75;
			8'h5D: xt_code = 8'h2B;
			8'h5E: xt_code = 8'h63;
			8'h5F: xt_code = 8'h76;
			8'h60: xt_code = 8'h55;
			8'h61: xt_code = 8'h56;
			8'h62: xt_code = 8'h77;
			8'h63: xt_code = 8'h78;
			8'h64: xt_code = 8'h79;
			8'h65: xt_code = 8'h7A;
			8'h66: xt_code = 8'h0E;
			8'h67: xt_code = 8'h7B;
			8'h68: xt_code = 8'h7C;
			8'h69: xt_code = 8'h4F;
			8'h6A: xt_code = 8'h7D;
			8'h6B: xt_code = 8'h4B;
			8'h6C: xt_code = 8'h47;
			8'h6D: xt_code = 8'h7E;
			8'h6E: xt_code = 8'h7F;
			8'h6F: xt_code = 8'h6F;
			8'h70: xt_code = 8'h52;
			8'h71: xt_code = 8'h53;
			8'h72: xt_code = 8'h50;
			8'h73: xt_code = 8'h4C;
			8'h74: xt_code = 8'h4D;
			8'h75: xt_code = 8'h48;
			8'h76: xt_code = 8'h01;  // Escape
			8'h77: xt_code = 8'h45;
			8'h78: xt_code = 8'h57;
			8'h79: xt_code = 8'h4E;
			8'h7A: xt_code = 8'h51;
			8'h7B: xt_code = 8'h4A;
			8'h7C: xt_code = 8'h37;
			8'h7D: xt_code = 8'h49;
			8'h7E: xt_code = 8'h46;
			8'h7F: xt_code = 8'h54;
			8'h80: xt_code = 8'h80;
			8'h81: xt_code = 8'h81;
			8'h82: xt_code = 8'h82;
			8'h83: xt_code = 8'h41;  // F7
			8'h84: xt_code = 8'h54;
			// Upper range passes through, 0xF0 included
			default: xt_code = rx_code;
		endcase
	end

endmodule

// File: src/xt_host_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT host side state machine
// Presents codes on pa with irq1, forms break codes,
// waits for the pb7 acknowledge, answers pb6 reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "kbd_settings.svh"

module xt_host_fsm import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_done,
	input  scan_code_t xt_code,
	input  logic       pb6,
	input  logic       pb7,
	output scan_code_t pa,
	output logic       irq1
);

	host_state_e state;
	logic        is_prefix;
	scan_code_t  break_code;

	// Translator passes 0xF0 through unchanged
	assign is_prefix = (xt_code == `KBD_BREAK_PREFIX);

	always_comb begin
		break_code = xt_code;
		break_code[`KBD_BREAK_BIT] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= HS_IDLE;
			pa    <= '0;
			irq1  <= 1'b0;
		end else if (!pb6) begin
			// Keyboard reset from the host wins everywhere, pa held
			state <= HS_RST_LOW;
			irq1  <= 1'b0;
		end else begin
			case (state)
				HS_IDLE: begin
					if (rx_done) begin
						if (is_prefix) begin
							state <= HS_BREAK_WAIT;
						end else begin
							state <= HS_HOLD;
							pa    <= xt_code;
							irq1  <= 1'b1;
						end
					end
				end
				HS_BREAK_WAIT: begin
					if (rx_done && !is_prefix) begin // Repeated prefix keeps waiting
						state <= HS_HOLD;
						pa    <= break_code;
						irq1  <= 1'b1;
					end
				end
				HS_HOLD: begin
					// Frames arriving here are dropped
					if (pb7) begin
						state <= HS_ACK;
						pa    <= '0;
						irq1  <= 1'b0;
					end
				end
				HS_ACK: begin
					if (!pb7) begin
						state <= HS_IDLE;
					end
				end
				HS_RST_LOW: begin
					state <= HS_RST_WAIT;  // pb6 is high here
				end
				HS_RST_WAIT: begin
					if (!pb7) begin
						state <= HS_HOLD;
						pa    <= `KBD_SELF_TEST_OK;
						irq1  <= 1'b1;
					end
				end
				default: begin
					state <= HS_IDLE;
					pa    <= '0;
					irq1  <= 1'b0;
				end
			endcase
		end
	end

	// Request only while a code is being held for the host
	a_irq_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		irq1 |-> state == HS_HOLD)
		else $error("irq1 high outside HS_HOLD");

	// Every way back to idle goes through a cleared pa
	a_pa_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		state == HS_IDLE |-> pa == '0)
		else $error("pa not zero in HS_IDLE");

endmodule

// File: src/xt_keyboard_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT keyboard port top level
// PS/2 receiver, set-2 to set-1 translation and
// the host handshake on pa, irq1, pb6 and pb7
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xt_keyboard_port import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       pb6,
	input  logic       pb7,
	output scan_code_t pa,
	output logic       irq1
);

	scan_code_t rx_code;  // Set-2 byte from the keyboard
	scan_code_t xt_code;
	logic       rx_done;

	ps2_receiver ps2_receiver_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_code  (rx_code),
		.rx_done  (rx_done)
	);

	scan_translator scan_translator_i (
		.rx_code (rx_code),
		.xt_code (xt_code)
	);

	// irq1 follows rx_done by one clk
	xt_host_fsm xt_host_fsm_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx_done (rx_done),
		.xt_code (xt_code),
		.pb6     (pb6),
		.pb7     (pb7),
		.pa      (pa),
		.irq1    (irq1)
	);

endmodule

// File: verification/tb_xt_keyboard_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT keyboard port testbench
// Sends PS/2 frames, acknowledges requests on pb7,
// runs the pb6 self-test, checks with assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_xt_keyboard_port;

	localparam int BIT_CYCLES  = 40;              // Keyboard bit period in clk cycles
	localparam int HALF_BIT    = BIT_CYCLES / 2;
	localparam int NUM_FRAMES  = 15;
	localparam int IRQ_LIMIT   = 200;             // Cycles to wait for irq1 after a frame
	localparam int WATCHDOG_NS = NUM_FRAMES * 15 * BIT_CYCLES * 10 + 20000;

	logic       clk;
	logic       rst_n;
	logic       ps2_clk;
	logic       ps2_data;
	logic       pb6;
	logic       pb7;
	logic [7:0] pa;
	logic       irq1;

	// Expected state, updated by the stimulus on falling edges
	logic [7:0]  exp_pa;
	logic        irq_allowed;
	logic        frame_started;
	logic [31:0] rng_state;

	// Set-2 codes and their set-1 values
	logic [7:0] set2_list [6] = '{8'h1C, 8'h29, 8'h5A, 8'h76, 8'h83, 8'h9A};
	logic [7:0] set1_list [6] = '{8'h1E, 8'h39, 8'h1C, 8'h01, 8'h41, 8'h9A};

	xt_keyboard_port dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Start, eight data bits LSB first, odd parity, stop
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		frame_started = 1'b1;
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];  // Data changes while ps2_clk is high
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b1;
		end
	endtask

	task automatic idle_gap();
		rng_state = next_random(rng_state);
		repeat (HALF_BIT + (rng_state % 60)) @(negedge clk);
	endtask

	task automatic wait_for_irq();
		int count;
		count = 0;
		while (!irq1 && count < IRQ_LIMIT) begin
			@(negedge clk);
			count++;
		end
		if (!irq1)
			fail_run("irq1 did not rise after the request was expected");
		else
			@(negedge clk);  // Lets the rise be sampled before irq_allowed drops
	endtask

	task automatic acknowledge();
		pb7 = 1'b1;
		repeat (3) @(negedge clk);
		pb7 = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic press_key(input logic [7:0] set2, input logic [7:0] set1);
		exp_pa      = set1;
		irq_allowed = 1'b1;
		send_frame(set2);
		wait_for_irq();
		irq_allowed = 1'b0;
	endtask

	// Prefix frames must not raise a request
	task automatic release_key(input logic [7:0] set2, input logic [7:0] set1, input int prefixes);
		exp_pa      = set1 | 8'h80;
		irq_allowed = 1'b0;
		for (int i = 0; i < prefixes; i++) begin
			send_frame(8'hF0);
			idle_gap();
		end
		press_key(set2, set1 | 8'h80);
	endtask

	task automatic keyboard_reset();
		pb6 = 1'b0;
		repeat (10) @(negedge clk);
		pb7 = 1'b1;  // Hold off the self-test byte for a while
		repeat (2) @(negedge clk);
		pb6 = 1'b1;
		repeat (5) @(negedge clk);
		exp_pa      = 8'hAA;
		irq_allowed = 1'b1;
		pb7         = 1'b0;
		wait_for_irq();
		irq_allowed = 1'b0;
	endtask

	// Quiet outputs until the first frame
	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!frame_started |-> (pa == 8'h00 && !irq1))
		else fail_run($sformatf("ERROR @ %0t: pa 0x%02h irq1 %b before any frame",
			$time, pa, irq1));

	a_rise_value: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq1) |-> pa == exp_pa)
		else fail_run($sformatf("ERROR @ %0t: pa 0x%02h at irq1 rise, expected 0x%02h",
			$time, pa, exp_pa));

	a_rise_allowed: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq1) |-> irq_allowed)
		else fail_run($sformatf("ERROR @ %0t: irq1 rose with no request expected", $time));

	a_ack_clears: assert property (@(posedge clk) disable iff (!rst_n)
		(irq1 && pb7 && pb6) |=> (!irq1 && pa == 8'h00))
		else fail_run($sformatf("ERROR @ %0t: pb7 did not clear irq1 and pa", $time));

	a_pb6_clears: assert property (@(posedge clk) disable iff (!rst_n)
		!pb6 |=> (!irq1 && $stable(pa)))
		else fail_run($sformatf("ERROR @ %0t: pb6 low left irq1 high or changed pa", $time));

	// A pending request holds pa against new frames
	a_pending_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(irq1 && !pb7 && pb6) |=> $stable(pa))
		else fail_run($sformatf("ERROR @ %0t: pa changed while a request was pending", $time));

	initial begin
		#(WATCHDOG_NS);
		fail_run("Timeout, the test did not finish before the watchdog expired");
	end

	initial begin
		rst_n         = 1'b0;
		ps2_clk       = 1'b1;
		ps2_data      = 1'b1;
		pb6           = 1'b1;
		pb7           = 1'b0;
		exp_pa        = 8'h00;
		irq_allowed   = 1'b0;
		frame_started = 1'b0;
		rng_state     = 32'd37;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (50) @(negedge clk);

		// Make codes, one identity code included
		for (int i = 0; i < 6; i++) begin
			press_key(set2_list[i], set1_list[i]);
			acknowledge();
			idle_gap();
		end

		release_key(8'h29, 8'h39, 1);
		acknowledge();
		idle_gap();
		release_key(8'h76, 8'h01, 2);  // Repeated prefix
		acknowledge();
		idle_gap();

		// Second frame arrives while the first is unacknowledged
		press_key(8'h5A, 8'h1C);
		idle_gap();
		send_frame(8'h1C);
		repeat (HALF_BIT) @(negedge clk);
		acknowledge();
		idle_gap();

		// Self-test with a request pending
		press_key(8'h1C, 8'h1E);
		keyboard_reset();
		acknowledge();
		idle_gap();

		press_key(8'h83, 8'h41);
		acknowledge();
		repeat (20) @(negedge clk);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: src.f
+incdir+src
src/kbd_pkg.sv
src/ps2_receiver.sv
src/scan_translator.sv
src/xt_host_fsm.sv
src/xt_keyboard_port.sv
verification/tb_xt_keyboard_port.sv

// File: Bender.yml
package:
  name: xt_keyboard_port

sources:
  - include_dirs:
      - src
    files:
      - src/kbd_pkg.sv
      - src/ps2_receiver.sv
      - src/scan_translator.sv
      - src/xt_host_fsm.sv
      - src/xt_keyboard_port.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/tb_xt_keyboard_port.sv
